// File: common/fir_pkg.sv
/*
 * shared widths, lane counts and pipeline latency for the fir filter
 * sample and product types, fixed symmetric coefficient table
 */

package fir_pkg;

	// ****************************************
	// widths and types
	// ****************************************

	localparam int SAMPLE_W = 18;

	// one sample, or one lane value anywhere in the pipeline
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// full precision product before scaling
	typedef logic signed [2*SAMPLE_W-1:0] product_t;

	// ****************************************
	// filter shape
	// ****************************************

	localparam int NUM_TAPS = 52;

	// symmetric taps share one coefficient per mirrored pair
	localparam int NUM_UNIQ = NUM_TAPS / 2;

	// products are normalized by this arithmetic shift
	localparam int SCALE_SHIFT = 17;

	// 26 -> 13 -> 7 -> 4 -> 2 -> 1
	localparam int TREE_LEVELS = 5;

	// delay line + fold + multiply + tree levels
	localparam int LATENCY = 3 + TREE_LEVELS;

	// first half of the impulse response, centre is between taps 25 and 26
	localparam sample_t COEFF [NUM_UNIQ] = '{
		18'sd88,
		18'sd0,
		-18'sd97,
		-18'sd197,
		-18'sd294,
		-18'sd380,
		-18'sd447,
		-18'sd490,
		-18'sd504,
		-18'sd481,
		-18'sd420,
		-18'sd319,
		-18'sd178,
		18'sd0,
		18'sd212,
		18'sd451,
		18'sd710,
		18'sd980,
		18'sd1252,
		18'sd1514,
		18'sd1756,
		18'sd1971,
		18'sd2147,
		18'sd2278,
		18'sd2360,
		18'sd2387
	};

endpackage

// File: hdl/tap_delay_line.sv
/*
 * sample shift register feeding the filter taps
 */

`timescale 1ns/1ns

module tap_delay_line
	import fir_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    i_clk_ena,
	input  logic    i_valid,
	input  sample_t i_sample,
	output sample_t o_taps [NUM_TAPS],
	output logic    o_valid
);

	sample_t taps_q [NUM_TAPS];
	logic    valid_q;

	// ****************************************
	// history shift
	// ****************************************

	// tap 0 holds the newest sample
	// invalid samples still shift in and stay part of the history
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_TAPS; i++) begin
				taps_q[i] <= '0;
			end
		end else if (i_clk_ena) begin
			taps_q[0] <= i_sample;
			for (int i = 1; i < NUM_TAPS; i++) begin
				taps_q[i] <= taps_q[i-1];
			end
		end
	end

	// flags the sample now in tap 0
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (i_clk_ena) begin
			valid_q <= i_valid;
		end
	end

	assign o_taps  = taps_q;
	assign o_valid = valid_q;

endmodule

// File: mac/symmetric_mac.sv
/*
 * folds mirrored taps into pair sums, then multiplies each sum
 * by its coefficient and scales the product back to sample width
 */

`timescale 1ns/1ns

module symmetric_mac
	import fir_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    i_clk_ena,
	input  sample_t i_taps [NUM_TAPS],
	input  logic    i_valid,
	output sample_t o_products [NUM_UNIQ],
	output logic    o_valid
);

	// stage 1 pair sums
	sample_t fold_q [NUM_UNIQ];
	logic    fold_valid_q;

	// stage 2 scaled products
	sample_t prod_q [NUM_UNIQ];
	logic    prod_valid_q;

	// full signed product, arithmetic shift, keep the low sample bits
	function automatic sample_t scale_product(sample_t a, sample_t c);
		product_t full;
		full = a * c;
		return sample_t'(full >>> SCALE_SHIFT);
	endfunction

	// ****************************************
	// stage 1 mirrored tap fold
	// ****************************************

	// tap i and tap 51-i share a coefficient, sum wraps at 18 bits
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_UNIQ; i++) begin
				fold_q[i] <= '0;
			end
			fold_valid_q <= 1'b0;
		end else if (i_clk_ena) begin
			for (int i = 0; i < NUM_UNIQ; i++) begin
				fold_q[i] <= i_taps[i] + i_taps[NUM_TAPS-1-i];
			end
			fold_valid_q <= i_valid;
		end
	end

	// ****************************************
	// stage 2 coefficient multiply
	// ****************************************

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < NUM_UNIQ; i++) begin
				prod_q[i] <= '0;
			end
			prod_valid_q <= 1'b0;
		end else if (i_clk_ena) begin
			for (int i = 0; i < NUM_UNIQ; i++) begin
				prod_q[i] <= scale_product(fold_q[i], COEFF[i]);
			end
			prod_valid_q <= fold_valid_q;
		end
	end

	assign o_products = prod_q;
	assign o_valid    = prod_valid_q;

endmodule

// File: adder_tree/adder_tree.sv
/*
 * registered pairwise adder tree over the scaled products
 * odd lanes are carried through a register to stay aligned
 */

`timescale 1ns/1ns

module adder_tree
	import fir_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    i_clk_ena,
	input  sample_t i_products [NUM_UNIQ],
	input  logic    i_valid,
	output sample_t o_sum,
	output logic    o_valid
);

	// one valid bit per tree level
	logic [TREE_LEVELS-1:0] valid_q;

	// ****************************************
	// summing levels
	// ****************************************

	genvar l;
	generate
		for (l = 1; l <= TREE_LEVELS; l = l + 1) begin : g_level
			// lane counts halve and round up at each level
			localparam int N_IN  = (NUM_UNIQ + (1 << (l - 1)) - 1) >> (l - 1);
			localparam int N_OUT = (N_IN + 1) / 2;

			sample_t prev [N_IN];
			sample_t sum_q [N_OUT];

			// level 1 reads the products, later levels read the level before
			if (l == 1) begin : g_src
				assign prev = i_products;
			end else begin : g_src
				assign prev = g_level[l-1].sum_q;
			end

			always_ff @(posedge clk or posedge reset) begin
				if (reset) begin
					for (int j = 0; j < N_OUT; j++) begin
						sum_q[j] <= '0;
					end
				end else if (i_clk_ena) begin
					// pair sums wrap at 18 bits
					for (int j = 0; j < N_IN / 2; j++) begin
						sum_q[j] <= prev[2*j] + prev[2*j+1];
					end
					// odd lane passes through unchanged
					if (N_IN % 2 == 1) begin
						sum_q[N_OUT-1] <= prev[N_IN-1];
					end
				end
			end
		end
	endgenerate

	// ****************************************
	// valid alignment
	// ****************************************

	// one register per level, tracks the data through the tree
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
		end else if (i_clk_ena) begin
			valid_q <= {valid_q[TREE_LEVELS-2:0], i_valid};
		end
	end

	// final level holds a single lane
	assign o_sum   = g_level[TREE_LEVELS].sum_q[0];
	assign o_valid = valid_q[TREE_LEVELS-1];

endmodule

// File: hdl/fir_filter.sv
/*
 * fir filter top level
 * delay line, symmetric multiply stage and adder tree
 */

`timescale 1ns/1ns

module fir_filter
	import fir_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    i_clk_ena,
	input  logic    i_valid,
	input  sample_t i_sample,
	output logic    o_valid,
	output sample_t o_sample
);

	// sample history out of the delay line
	sample_t taps [NUM_TAPS];
	logic    tap_valid;

	// scaled products, one per coefficient
	sample_t products [NUM_UNIQ];
	logic    prod_valid;

	// ****************************************
	// pipeline stages
	// ****************************************

	tap_delay_line u_tap_delay_line (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_sample  (i_sample),
		.o_taps    (taps),
		.o_valid   (tap_valid)
	);

	symmetric_mac u_symmetric_mac (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_taps     (taps),
		.i_valid    (tap_valid),
		.o_products (products),
		.o_valid    (prod_valid)
	);

	// last tree level is the output register
	adder_tree u_adder_tree (
		.clk        (clk),
		.reset      (reset),
		.i_clk_ena  (i_clk_ena),
		.i_products (products),
		.i_valid    (prod_valid),
		.o_sum      (o_sample),
		.o_valid    (o_valid)
	);

endmodule

// File: dv/fir_model.svh
/*
 * reference model for the fir filter testbench
 * sample history, window arithmetic and expected output queue
 */

`ifndef FIR_MODEL_SVH
`define FIR_MODEL_SVH

// ****************************************
// model state
// ****************************************

// index 0 holds the newest sample
sample_t model_hist [NUM_TAPS];

// expected outputs, head is what the DUT shows right now
sample_t exp_sample_q [$];
logic    exp_valid_q [$];

// empty history, pipeline full of zero results with valid low
function automatic void clear_history();
	for (int i = 0; i < NUM_TAPS; i++) begin
		model_hist[i] = '0;
	end
	exp_sample_q.delete();
	exp_valid_q.delete();
	for (int i = 0; i < LATENCY; i++) begin
		exp_sample_q.push_back('0);
		exp_valid_q.push_back(1'b0);
	end
endfunction

// filter output for the window now in the history
function automatic sample_t window_output();
	sample_t pair;
	longint  prod;
	int      acc;
	acc = 0;
	for (int i = 0; i < NUM_UNIQ; i++) begin
		// mirrored pair, wraps at sample width
		pair = model_hist[i] + model_hist[NUM_TAPS-1-i];
		prod = longint'(pair) * longint'(COEFF[i]);
		// arithmetic shift, then keep the low sample bits
		acc = acc + int'(sample_t'(prod >>> SCALE_SHIFT));
	end
	// wrapping sums are order free, so one final truncation matches the tree
	return sample_t'(acc);
endfunction

// one enabled edge, the DUT captures smp and vld
function automatic void advance_model(input sample_t smp, input logic vld);
	for (int i = NUM_TAPS - 1; i > 0; i--) begin
		model_hist[i] = model_hist[i-1];
	end
	model_hist[0] = smp;
	exp_sample_q.push_back(window_output());
	exp_valid_q.push_back(vld);
	// oldest result leaves, LATENCY entries stay in flight
	void'(exp_sample_q.pop_front());
	void'(exp_valid_q.pop_front());
endfunction

`endif

// File: dv/fir_tb.sv
/*
 * fir filter testbench with clock, reset, checker and watchdog
 * impulse, random stream, enable gap, wraparound and reset phases
 */

`timescale 1ns/1ns

module fir_tb
	import fir_pkg::*;
();

	// ****************************************
	// run lengths
	// ****************************************

	localparam int CLK_HALF          = 50;
	localparam int RESET_CYCLES      = 16;
	localparam int IMPULSE_CYCLES    = LATENCY + NUM_TAPS + 4;
	localparam int STREAM_CYCLES     = 400;
	localparam int WRAP_CYCLES       = 100;
	localparam int PRE_RESET_CYCLES  = 60;
	localparam int HOLD_RESET_CYCLES = 4;
	localparam int POST_RESET_CYCLES = 120;
	localparam int MARGIN_CYCLES     = 200;

	// every phase plus its drain and some slack
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 1 + IMPULSE_CYCLES
		+ 2 * (STREAM_CYCLES + LATENCY) + WRAP_CYCLES + LATENCY
		+ PRE_RESET_CYCLES + 1 + HOLD_RESET_CYCLES + 1 + POST_RESET_CYCLES
		+ LATENCY + MARGIN_CYCLES;

	localparam int      IMPULSE_AMP = 1024;
	localparam int      GAP_PERCENT = 30;
	localparam sample_t FULL_POS    = 18'sh1FFFF;
	localparam sample_t FULL_NEG    = 18'sh20000;

	logic    clk;
	logic    reset;
	logic    clk_ena;
	logic    valid_in;
	sample_t sample_in;
	logic    valid_out;
	sample_t sample_out;

	string       phase_name;
	int unsigned seed_value;

	// outputs and controls seen at the previous falling edge
	sample_t held_sample;
	logic    held_valid;
	logic    last_ena;
	logic    last_reset;

	`include "fir_model.svh"

	fir_filter dut (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (clk_ena),
		.i_valid   (valid_in),
		.i_sample  (sample_in),
		.o_valid   (valid_out),
		.o_sample  (sample_out)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// ****************************************
	// helpers
	// ****************************************

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic compare_value(input string what, input sample_t expected,
		input sample_t actual);
		assert (actual === expected) else begin
			$display("Mismatch in %s: %s expected %0d actual %0d",
				phase_name, what, expected, actual);
			stop_run();
		end
	endtask

	task automatic drive_inputs(input logic ena, input logic vld, input sample_t smp);
		@(posedge clk);
		clk_ena   <= ena;
		valid_in  <= vld;
		sample_in <= smp;
	endtask

	function automatic sample_t random_sample();
		return sample_t'($urandom);
	endfunction

	function automatic logic random_bit();
		return ($urandom_range(1, 0) == 1);
	endfunction

	// scaled coefficient seen when the impulse sits in tap k
	function automatic sample_t impulse_response(input int k);
		int idx;
		int prod;
		idx  = (k < NUM_UNIQ) ? k : NUM_TAPS - 1 - k;
		prod = IMPULSE_AMP * int'(COEFF[idx]);
		return sample_t'(prod >>> SCALE_SHIFT);
	endfunction

	// idle edges so the last samples reach the output
	task automatic drain_pipeline();
		repeat (LATENCY) drive_inputs(1'b1, 1'b0, '0);
	endtask

	// ****************************************
	// output checker
	// ****************************************

	// outputs are settled and the next inputs already driven at the falling edge
	always @(negedge clk) begin
		if (reset) begin
			clear_history();
		end
		compare_value("o_sample", exp_sample_q[0], sample_out);
		compare_value("o_valid", exp_valid_q[0], valid_out);
		// a disabled edge must leave the outputs untouched
		if (!reset && !last_reset && !last_ena) begin
			compare_value("held o_sample", held_sample, sample_out);
			compare_value("held o_valid", held_valid, valid_out);
		end
		held_sample = sample_out;
		held_valid  = valid_out;
		last_ena    = clk_ena;
		last_reset  = reset;
		// inputs now on the pins are captured at the next rising edge
		if (!reset && clk_ena) begin
			advance_model(sample_in, valid_in);
		end
	end

	// ****************************************
	// test phases
	// ****************************************

	task automatic run_impulse();
		sample_t exp_smp;
		logic    exp_vld;
		phase_name = "impulse";
		drive_inputs(1'b1, 1'b1, sample_t'(IMPULSE_AMP));
		// edge n is the n-th enabled edge counting the capture as 1
		for (int n = 1; n <= IMPULSE_CYCLES; n++) begin
			drive_inputs(1'b1, 1'b0, '0);
			@(negedge clk);
			exp_vld = (n == LATENCY);
			exp_smp = '0;
			if (n >= LATENCY && n - LATENCY < NUM_TAPS) begin
				exp_smp = impulse_response(n - LATENCY);
			end
			compare_value("impulse o_sample", exp_smp, sample_out);
			compare_value("impulse o_valid", exp_vld, valid_out);
		end
	endtask

	task automatic run_stream(input string name, input logic gaps);
		logic ena;
		phase_name = name;
		for (int i = 0; i < STREAM_CYCLES; i++) begin
			ena = 1'b1;
			if (gaps) begin
				ena = ($urandom_range(99, 0) >= GAP_PERCENT);
			end
			drive_inputs(ena, random_bit(), random_sample());
		end
		drain_pipeline();
	endtask

	// all positive then all negative then a random mix of both rails
	task automatic run_wrap();
		sample_t smp;
		phase_name = "wraparound";
		for (int i = 0; i < WRAP_CYCLES; i++) begin
			if (i < WRAP_CYCLES / 3) begin
				smp = FULL_POS;
			end else if (i < 2 * WRAP_CYCLES / 3) begin
				smp = FULL_NEG;
			end else begin
				smp = random_bit() ? FULL_POS : FULL_NEG;
			end
			drive_inputs(1'b1, 1'b1, smp);
		end
		drain_pipeline();
	endtask

	task automatic run_reset_mid();
		phase_name = "reset mid-stream";
		repeat (PRE_RESET_CYCLES) drive_inputs(1'b1, random_bit(), random_sample());
		@(posedge clk);
		reset     <= 1'b1;
		clk_ena   <= 1'b1;
		valid_in  <= 1'b1;
		sample_in <= random_sample();
		@(negedge clk);
		compare_value("o_valid in reset", 1'b0, valid_out);
		compare_value("o_sample in reset", '0, sample_out);
		// traffic keeps coming while reset is held
		repeat (HOLD_RESET_CYCLES) drive_inputs(1'b1, random_bit(), random_sample());
		@(posedge clk);
		reset <= 1'b0;
		repeat (POST_RESET_CYCLES) drive_inputs(1'b1, random_bit(), random_sample());
		drain_pipeline();
	endtask

	// ****************************************
	// main sequence and watchdog
	// ****************************************

	initial begin
		phase_name  = "reset";
		last_ena    = 1'b0;
		last_reset  = 1'b1;
		reset       = 1'b1;
		clk_ena     = 1'b0;
		valid_in    = 1'b0;
		sample_in   = '0;
		seed_value  = $urandom(32'h9422);
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		run_impulse();
		run_stream("random stream", 1'b0);
		run_stream("enable gaps", 1'b1);
		run_wrap();
		run_reset_mid();
		$display("PASS: all tests");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles in %s",
			WATCHDOG_CYCLES, phase_name);
		stop_run();
	end

endmodule

// File: vlog.f
+incdir+dv
common/fir_pkg.sv
hdl/tap_delay_line.sv
mac/symmetric_mac.sv
adder_tree/adder_tree.sv
hdl/fir_filter.sv
dv/fir_tb.sv
